/* common/soc_xbar_macros.svh */
`ifndef SOC_XBAR_MACROS_SVH
`define SOC_XBAR_MACROS_SVH

////////////////////////////////////////
// SoC memory map
////////////////////////////////////////

// Core private bank 0, code and data of the fabric controller
`define SOC_MEM_MAP_PRIVATE_BANK0_START_ADDR 32'h1C00_0000
`define SOC_MEM_MAP_PRIVATE_BANK0_END_ADDR   32'h1C00_7FFF

// Core private bank 1, directly follows bank 0
`define SOC_MEM_MAP_PRIVATE_BANK1_START_ADDR 32'h1C00_8000
`define SOC_MEM_MAP_PRIVATE_BANK1_END_ADDR   32'h1C00_FFFF

// Boot ROM, read only
`define SOC_MEM_MAP_BOOT_ROM_START_ADDR      32'h1A00_0000
`define SOC_MEM_MAP_BOOT_ROM_END_ADDR        32'h1A00_3FFF

// Peripheral region behind the APB bridge
`define SOC_MEM_MAP_PERIPHERALS_START_ADDR   32'h1A10_0000
`define SOC_MEM_MAP_PERIPHERALS_END_ADDR     32'h1A1F_FFFF

////////////////////////////////////////
// Legacy address alias
////////////////////////////////////////

// Prefix 0x000 of the data port maps onto the private banks
`define SOC_ALIAS_PREFIX_FROM 12'h000
`define SOC_ALIAS_PREFIX_TO   12'h1C0

// Largest number of APB access cycles before the bridge gives up
`define SOC_APB_TIMEOUT_CYCLES 16

`endif

/* common/soc_xbar_pkg.sv */
`default_nettype none

package soc_xbar_pkg;

    ////////////////////////////////////////
    // Bus words
    ////////////////////////////////////////

    // Data or address word of the request/grant bus
    typedef logic [31:0] word_t;

    // One enable per byte lane
    typedef logic [3:0] be_t;

    // Address split used by the alias rule
    typedef struct packed {
        logic [11:0] prefix;
        logic [19:0] offset;
    } soc_addr_fields_t;

    // Same address word, seen whole for range matching or split for the alias
    typedef union packed {
        word_t            word;
        soc_addr_fields_t fields;
    } soc_addr_u;

    ////////////////////////////////////////
    // Routing codes
    ////////////////////////////////////////

    // Where a request ends up
    typedef enum logic [1:0] {
        TGT_CONTIG = 2'd0,
        TGT_PERIPH = 2'd1,
        TGT_ERROR  = 2'd2
    } target_e;

    // Slave behind the contiguous memory port
    typedef enum logic [1:0] {
        SEL_BANK0   = 2'd0,
        SEL_BANK1   = 2'd1,
        SEL_BOOTROM = 2'd2
    } contig_sel_e;

endpackage

`default_nettype wire

/* rtl/soc_addr_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_xbar_macros.svh"

module soc_addr_decode
    import soc_xbar_pkg::*;
(
    input  word_t       fc_add_i,
    input  logic        fc_wen_i,
    output word_t       addr_o,
    output target_e     target_o,
    output contig_sel_e contig_sel_o
);

    soc_addr_u remap_addr;

    ////////////////////////////////////////
    // Alias remap
    ////////////////////////////////////////

    always_comb begin
        remap_addr.word = fc_add_i;
        // Old software still uses the zero page for the private banks
        if (remap_addr.fields.prefix == `SOC_ALIAS_PREFIX_FROM) begin
            remap_addr.fields.prefix = `SOC_ALIAS_PREFIX_TO;
        end
    end

    assign addr_o = remap_addr.word;

    ////////////////////////////////////////
    // Region match
    ////////////////////////////////////////

    always_comb begin
        // Anything not matched below is unmapped
        target_o     = TGT_ERROR;
        contig_sel_o = SEL_BANK0;
        if (remap_addr.word >= `SOC_MEM_MAP_PRIVATE_BANK0_START_ADDR &&
            remap_addr.word <= `SOC_MEM_MAP_PRIVATE_BANK0_END_ADDR) begin
            target_o     = TGT_CONTIG;
            contig_sel_o = SEL_BANK0;
        end else if (remap_addr.word >= `SOC_MEM_MAP_PRIVATE_BANK1_START_ADDR &&
                     remap_addr.word <= `SOC_MEM_MAP_PRIVATE_BANK1_END_ADDR) begin
            target_o     = TGT_CONTIG;
            contig_sel_o = SEL_BANK1;
        end else if (remap_addr.word >= `SOC_MEM_MAP_BOOT_ROM_START_ADDR &&
                     remap_addr.word <= `SOC_MEM_MAP_BOOT_ROM_END_ADDR) begin
            // ROM takes reads only, wen high means read
            if (fc_wen_i) begin
                target_o     = TGT_CONTIG;
                contig_sel_o = SEL_BOOTROM;
            end
        end else if (remap_addr.word >= `SOC_MEM_MAP_PERIPHERALS_START_ADDR &&
                     remap_addr.word <= `SOC_MEM_MAP_PERIPHERALS_END_ADDR) begin
            target_o = TGT_PERIPH;
        end
    end

endmodule

`default_nettype wire

/* rtl/soc_contig_router.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_contig_router
    import soc_xbar_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        req_i,
    input  target_e     target_i,
    input  contig_sel_e sel_i,
    input  word_t       addr_i,
    input  logic        wen_i,
    input  word_t       wdata_i,
    input  be_t         be_i,
    input  logic        bridge_busy_i,
    input  logic        mem_gnt_i,
    input  logic        mem_r_valid_i,
    input  word_t       mem_r_rdata_i,
    output logic        gnt_o,
    output logic        r_valid_o,
    output word_t       r_rdata_o,
    output logic        r_opc_o,
    output logic        mem_req_o,
    output contig_sel_e mem_sel_o,
    output word_t       mem_add_o,
    output logic        mem_wen_o,
    output word_t       mem_wdata_o,
    output be_t         mem_be_o
);

    logic err_gnt;
    logic err_pend_q;

    ////////////////////////////////////////
    // Request side
    ////////////////////////////////////////

    // An APB transfer in flight blocks all grants to keep response order
    assign mem_req_o   = req_i && (target_i == TGT_CONTIG) && !bridge_busy_i;
    assign mem_sel_o   = sel_i;
    assign mem_add_o   = addr_i;
    assign mem_wen_o   = wen_i;
    assign mem_wdata_o = wdata_i;
    assign mem_be_o    = be_i;

    // Errors are accepted at once, they never leave this block
    assign err_gnt = req_i && (target_i == TGT_ERROR) && !bridge_busy_i;
    assign gnt_o   = (mem_req_o && mem_gnt_i) || err_gnt;

    ////////////////////////////////////////
    // Response side
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            err_pend_q <= 1'b0;
        end else begin
            err_pend_q <= err_gnt;
        end
    end

    // One grant per cycle, so memory and error responses never overlap
    assign r_valid_o = mem_r_valid_i || err_pend_q;
    assign r_rdata_o = err_pend_q ? '0 : mem_r_rdata_i;
    assign r_opc_o   = err_pend_q;

endmodule

`default_nettype wire

/* apb_bridge/apb_timeout_counter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_xbar_macros.svh"

module apb_timeout_counter (
    input  logic clk_i,
    input  logic reset_i,
    input  logic count_en_i,
    output logic expired_o
);

    // Wide enough to hold the full timeout length
    localparam int unsigned CNT_W = $clog2(`SOC_APB_TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] count_q;

    // Cycles of the current access phase seen before this one
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (!count_en_i) begin
            count_q <= '0;
        end else if (!expired_o) begin
            count_q <= count_q + 1'b1;
        end
    end

    // High in the last allowed access cycle, counting this one
    assign expired_o = count_en_i && (count_q == CNT_W'(`SOC_APB_TIMEOUT_CYCLES - 1));

endmodule

`default_nettype wire

/* apb_bridge/apb_bridge_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_bridge_fsm
    import soc_xbar_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    req_i,
    input  target_e target_i,
    input  word_t   addr_i,
    input  logic    wen_i,
    input  word_t   wdata_i,
    input  be_t     be_i,
    input  logic    apb_pready_i,
    input  word_t   apb_prdata_i,
    input  logic    apb_pslverr_i,
    output logic    gnt_o,
    output logic    busy_o,
    output logic    r_valid_o,
    output word_t   r_rdata_o,
    output logic    r_opc_o,
    output word_t   apb_paddr_o,
    output logic    apb_psel_o,
    output logic    apb_penable_o,
    output logic    apb_pwrite_o,
    output word_t   apb_pwdata_o,
    output be_t     apb_pstrb_o
);

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS, RESP} apb_state_e;

    apb_state_e state_q;
    apb_state_e state_d;
    word_t      addr_q;
    word_t      wdata_q;
    be_t        be_q;
    logic       wen_q;
    word_t      rdata_q;
    logic       opc_q;
    logic       expired;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    // Only one transfer at a time, new ones are taken in IDLE
    assign gnt_o = (state_q == IDLE) && req_i && (target_i == TGT_PERIPH);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (gnt_o) state_d = SETUP;
            SETUP:   state_d = ACCESS;
            ACCESS:  if (apb_pready_i || expired) state_d = RESP;
            RESP:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Counts access cycles of a slave that keeps pready low
    apb_timeout_counter u_timeout (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .count_en_i (state_q == ACCESS),
        .expired_o  (expired)
    );

    ////////////////////////////////////////
    // Data capture
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        // Request is frozen at grant so the APB side stays stable
        if (gnt_o) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            be_q    <= be_i;
            wen_q   <= wen_i;
        end
        if (state_q == ACCESS) begin
            if (apb_pready_i) begin
                rdata_q <= wen_q ? apb_prdata_i : '0;
                opc_q   <= apb_pslverr_i;
            end else if (expired) begin
                // Timed out, report an error with no data
                rdata_q <= '0;
                opc_q   <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    assign busy_o        = (state_q != IDLE);
    assign apb_psel_o    = (state_q == SETUP) || (state_q == ACCESS);
    assign apb_penable_o = (state_q == ACCESS);
    assign apb_paddr_o   = addr_q;
    assign apb_pwrite_o  = ~wen_q;
    assign apb_pwdata_o  = wdata_q;
    assign apb_pstrb_o   = wen_q ? '0 : be_q; // no strobes on reads
    assign r_valid_o     = (state_q == RESP);
    assign r_rdata_o     = rdata_q;
    assign r_opc_o       = opc_q;

endmodule

`default_nettype wire

/* rtl/soc_xbar_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_xbar_top
    import soc_xbar_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    // Fabric controller data port
    input  logic        fc_req_i,
    input  word_t       fc_add_i,
    input  logic        fc_wen_i,
    input  word_t       fc_wdata_i,
    input  be_t         fc_be_i,
    output logic        fc_gnt_o,
    output logic        fc_r_valid_o,
    output word_t       fc_r_rdata_o,
    output logic        fc_r_opc_o,
    // Contiguous memory port
    output logic        mem_req_o,
    output contig_sel_e mem_sel_o,
    output word_t       mem_add_o,
    output logic        mem_wen_o,
    output word_t       mem_wdata_o,
    output be_t         mem_be_o,
    input  logic        mem_gnt_i,
    input  logic        mem_r_valid_i,
    input  word_t       mem_r_rdata_i,
    // Peripheral APB port
    output word_t       apb_paddr_o,
    output logic        apb_psel_o,
    output logic        apb_penable_o,
    output logic        apb_pwrite_o,
    output word_t       apb_pwdata_o,
    output be_t         apb_pstrb_o,
    input  logic        apb_pready_i,
    input  word_t       apb_prdata_i,
    input  logic        apb_pslverr_i
);

    word_t       dec_addr;
    target_e     dec_target;
    contig_sel_e dec_sel;
    logic        bridge_busy;
    logic        rtr_gnt;
    logic        rtr_r_valid;
    word_t       rtr_r_rdata;
    logic        rtr_r_opc;
    logic        apb_gnt;
    logic        apb_r_valid;
    word_t       apb_r_rdata;
    logic        apb_r_opc;

    soc_addr_decode u_decode (
        .fc_add_i     (fc_add_i),
        .fc_wen_i     (fc_wen_i),
        .addr_o       (dec_addr),
        .target_o     (dec_target),
        .contig_sel_o (dec_sel)
    );

    soc_contig_router u_router (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_i         (fc_req_i),
        .target_i      (dec_target),
        .sel_i         (dec_sel),
        .addr_i        (dec_addr),
        .wen_i         (fc_wen_i),
        .wdata_i       (fc_wdata_i),
        .be_i          (fc_be_i),
        .bridge_busy_i (bridge_busy),
        .mem_gnt_i     (mem_gnt_i),
        .mem_r_valid_i (mem_r_valid_i),
        .mem_r_rdata_i (mem_r_rdata_i),
        .gnt_o         (rtr_gnt),
        .r_valid_o     (rtr_r_valid),
        .r_rdata_o     (rtr_r_rdata),
        .r_opc_o       (rtr_r_opc),
        .mem_req_o     (mem_req_o),
        .mem_sel_o     (mem_sel_o),
        .mem_add_o     (mem_add_o),
        .mem_wen_o     (mem_wen_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_be_o      (mem_be_o)
    );

    apb_bridge_fsm u_apb_bridge (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_i         (fc_req_i),
        .target_i      (dec_target),
        .addr_i        (dec_addr),
        .wen_i         (fc_wen_i),
        .wdata_i       (fc_wdata_i),
        .be_i          (fc_be_i),
        .apb_pready_i  (apb_pready_i),
        .apb_prdata_i  (apb_prdata_i),
        .apb_pslverr_i (apb_pslverr_i),
        .gnt_o         (apb_gnt),
        .busy_o        (bridge_busy),
        .r_valid_o     (apb_r_valid),
        .r_rdata_o     (apb_r_rdata),
        .r_opc_o       (apb_r_opc),
        .apb_paddr_o   (apb_paddr_o),
        .apb_psel_o    (apb_psel_o),
        .apb_penable_o (apb_penable_o),
        .apb_pwrite_o  (apb_pwrite_o),
        .apb_pwdata_o  (apb_pwdata_o),
        .apb_pstrb_o   (apb_pstrb_o)
    );

    ////////////////////////////////////////
    // Response merge
    ////////////////////////////////////////

    // Busy bridge stalls the router, so both paths never fire together
    assign fc_gnt_o     = rtr_gnt | apb_gnt;
    assign fc_r_valid_o = rtr_r_valid | apb_r_valid;
    assign fc_r_rdata_o = apb_r_valid ? apb_r_rdata : rtr_r_rdata;
    assign fc_r_opc_o   = apb_r_valid ? apb_r_opc : rtr_r_opc;

endmodule

`default_nettype wire

/* bench/soc_xbar_sva.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_xbar_macros.svh"

module soc_xbar_sva
    import soc_xbar_pkg::*;
(
    input logic  clk_i,
    input logic  reset_i,
    input logic  fc_gnt_i,
    input logic  fc_r_valid_i,
    input logic  apb_psel_i,
    input logic  apb_penable_i,
    input word_t apb_paddr_i,
    input word_t apb_pwdata_i
);

    // Read by the testbench
    int unsigned fail_count = 0;

    ////////////////////////////////////////
    // APB protocol
    ////////////////////////////////////////

    penable_with_psel: assert property (@(posedge clk_i) disable iff (reset_i)
        apb_penable_i |-> apb_psel_i)
        else begin
            fail_count++;
            $error("penable high without psel");
        end

    // Address and data frozen for the whole transfer
    apb_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        $past(apb_psel_i) && apb_psel_i |-> $stable(apb_paddr_i) && $stable(apb_pwdata_i))
        else begin
            fail_count++;
            $error("paddr or pwdata changed during a transfer");
        end

    // Longest path is the APB timeout plus setup and response
    resp_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        fc_gnt_i |-> ##[1:(`SOC_APB_TIMEOUT_CYCLES + 3)] fc_r_valid_i)
        else begin
            fail_count++;
            $error("no response in time after a grant");
        end

endmodule

bind soc_xbar_top soc_xbar_sva u_sva (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fc_gnt_i      (fc_gnt_o),
    .fc_r_valid_i  (fc_r_valid_o),
    .apb_psel_i    (apb_psel_o),
    .apb_penable_i (apb_penable_o),
    .apb_paddr_i   (apb_paddr_o),
    .apb_pwdata_i  (apb_pwdata_o)
);

`default_nettype wire

/* bench/tb_soc_xbar.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_xbar_macros.svh"

module tb_soc_xbar
    import soc_xbar_pkg::*;
();

    // Port codes of the pattern file where 0 means no port
    localparam int PORT_MEM = 1;
    localparam int PORT_APB = 2;

    // Cycle limits of the waits below
    localparam int GNT_TIMEOUT   = 64;
    localparam int DRAIN_TIMEOUT = 64;

    logic        clk_i;
    logic        reset_i;
    logic        fc_req_i;
    word_t       fc_add_i;
    logic        fc_wen_i;
    word_t       fc_wdata_i;
    be_t         fc_be_i;
    logic        fc_gnt_o;
    logic        fc_r_valid_o;
    word_t       fc_r_rdata_o;
    logic        fc_r_opc_o;
    logic        mem_req_o;
    contig_sel_e mem_sel_o;
    word_t       mem_add_o;
    logic        mem_wen_o;
    word_t       mem_wdata_o;
    be_t         mem_be_o;
    logic        mem_gnt_i;
    logic        mem_r_valid_i;
    word_t       mem_r_rdata_i;
    word_t       apb_paddr_o;
    logic        apb_psel_o;
    logic        apb_penable_o;
    logic        apb_pwrite_o;
    word_t       apb_pwdata_o;
    be_t         apb_pstrb_o;
    logic        apb_pready_i;
    word_t       apb_prdata_i;
    logic        apb_pslverr_i;

    // One entry per pattern line
    logic        pat_wen[$];
    word_t       pat_addr[$];
    word_t       pat_wdata[$];
    be_t         pat_be[$];
    int          pat_wait[$];
    logic        pat_slverr[$];
    int          pat_port[$];
    contig_sel_e pat_sel[$];
    word_t       pat_exp_addr[$];
    word_t       pat_exp_rdata[$];
    logic        pat_exp_opc[$];

    // Granted requests still waiting for a response with the oldest first
    int          resp_q[$];
    int          apb_q[$];
    logic        apb_pend;
    int          cur_idx;
    int          apb_idx;
    int          apb_left;
    int          apb_access;
    int          resp_idx;
    word_t       mem_store[word_t];

    soc_xbar_top u_dut (.*);

    always #50 clk_i = ~clk_i;

    ////////////////////////////////////////
    // Reporting and compare
    ////////////////////////////////////////

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic stop_with_error(input string what);
        $display("Error at %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_sel(input string name, input contig_sel_e got, input contig_sel_e exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_opc(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // Slave data
    ////////////////////////////////////////

    // Every address bit shows up in the data
    function automatic word_t mem_fill_value(input word_t addr);
        return addr ^ 32'h5A5A_5A5A;
    endfunction

    function automatic word_t apb_fill_value(input word_t addr);
        return addr ^ 32'hC3C3_3C3C;
    endfunction

    function automatic word_t mem_read_word(input word_t addr);
        if (mem_store.exists(addr)) begin
            return mem_store[addr];
        end
        return mem_fill_value(addr);
    endfunction

    // Only enabled byte lanes change
    function automatic void mem_write_word(input word_t addr, input word_t data, input be_t be);
        word_t cur;
        int    b;
        cur = mem_read_word(addr);
        for (b = 0; b < 4; b++) begin
            if (be[b]) begin
                cur[8*b +: 8] = data[8*b +: 8];
            end
        end
        mem_store[addr] = cur;
    endfunction

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [31:0] col [11];
        fd = $fopen("bench/soc_xbar_patterns.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open the pattern file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %d %h %d %h %h %h %h", col[0], col[1],
                            col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                            col[9], col[10]);
                // Comment and blank lines do not parse
                if (n == 11) begin
                    pat_wen.push_back(col[0][0]);
                    pat_addr.push_back(col[1]);
                    pat_wdata.push_back(col[2]);
                    pat_be.push_back(col[3][3:0]);
                    pat_wait.push_back(int'(col[4]));
                    pat_slverr.push_back(col[5][0]);
                    pat_port.push_back(int'(col[6]));
                    pat_sel.push_back(contig_sel_e'(col[7][1:0]));
                    pat_exp_addr.push_back(col[8]);
                    pat_exp_rdata.push_back(col[9]);
                    pat_exp_opc.push_back(col[10][0]);
                end
            end
            $fclose(fd);
        end
    endtask

    // Keeps response order and flags grants that overtake an APB transfer
    task automatic record_grant(input int idx);
        if (apb_pend) begin
            stop_with_error("request granted while an APB transfer is pending");
        end
        resp_q.push_back(idx);
        if (pat_port[idx] == PORT_APB) begin
            apb_q.push_back(idx);
            apb_pend = 1'b1;
        end
    endtask

    task automatic drive_apb_ready();
        apb_pready_i  <= 1'b1;
        apb_pslverr_i <= pat_slverr[apb_idx];
        apb_prdata_i  <= apb_fill_value(apb_paddr_o);
    endtask

    ////////////////////////////////////////
    // Memory slave
    ////////////////////////////////////////

    always @(posedge clk_i) begin
        // Random back-pressure in about one cycle of four
        mem_gnt_i     <= (($urandom % 4) != 0);
        mem_r_valid_i <= 1'b0;
        mem_r_rdata_i <= '0;
        if (!reset_i && mem_req_o) begin
            if (pat_port[cur_idx] != PORT_MEM) begin
                stop_with_error("memory request for a transaction of another port");
            end else if (!mem_gnt_i && fc_gnt_o) begin
                stop_with_error("grant given while the memory port held it off");
            end else if (mem_gnt_i) begin
                check_word("mem_add_o", mem_add_o, pat_exp_addr[cur_idx]);
                check_sel("mem_sel_o", mem_sel_o, pat_sel[cur_idx]);
                check_word("mem_wen_o", word_t'(mem_wen_o), word_t'(pat_wen[cur_idx]));
                if (mem_wen_o) begin
                    mem_r_rdata_i <= mem_read_word(mem_add_o);
                end else begin
                    check_word("mem_wdata_o", mem_wdata_o, pat_wdata[cur_idx]);
                    check_word("mem_be_o", word_t'(mem_be_o), word_t'(pat_be[cur_idx]));
                    mem_write_word(mem_add_o, mem_wdata_o, mem_be_o);
                end
                // Answer in the cycle after the grant
                mem_r_valid_i <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // APB slave
    ////////////////////////////////////////

    always @(posedge clk_i) begin
        apb_pready_i  <= 1'b0;
        apb_pslverr_i <= 1'b0;
        apb_prdata_i  <= '0;
        if (reset_i) begin
            apb_left   = 0;
            apb_access = 0;
        end else if (apb_psel_o && !apb_penable_o) begin
            // Setup phase
            if (apb_q.size() == 0) begin
                stop_with_error("APB transfer without a granted peripheral request");
            end else begin
                apb_idx    = apb_q.pop_front();
                apb_left   = pat_wait[apb_idx];
                apb_access = 0;
                check_word("apb_paddr_o", apb_paddr_o, pat_exp_addr[apb_idx]);
                check_word("apb_pwrite_o", word_t'(apb_pwrite_o), word_t'(!pat_wen[apb_idx]));
                check_word("apb_pwdata_o", apb_pwdata_o, pat_wdata[apb_idx]);
                // Reads carry no strobes
                check_word("apb_pstrb_o", word_t'(apb_pstrb_o),
                           pat_wen[apb_idx] ? '0 : word_t'(pat_be[apb_idx]));
                if (apb_left == 0) begin
                    drive_apb_ready();
                end
            end
        end else if (apb_psel_o && apb_penable_o && !apb_pready_i) begin
            // Access cycle that ended without pready
            apb_access++;
            if (apb_access > `SOC_APB_TIMEOUT_CYCLES) begin
                stop_with_error("psel still high after the APB timeout");
            end else if (apb_left > 0) begin
                apb_left--;
                if (apb_left == 0) begin
                    drive_apb_ready();
                end
            end
        end
    end

    ////////////////////////////////////////
    // Response check at mid cycle
    ////////////////////////////////////////

    always @(negedge clk_i) begin
        if (!reset_i && fc_r_valid_o) begin
            if (resp_q.size() == 0) begin
                stop_with_error("response without an outstanding request");
            end else begin
                resp_idx = resp_q.pop_front();
                check_word("fc_r_rdata_o", fc_r_rdata_o, pat_exp_rdata[resp_idx]);
                check_opc("fc_r_opc_o", fc_r_opc_o, pat_exp_opc[resp_idx]);
                if (pat_port[resp_idx] == PORT_APB) begin
                    apb_pend = 1'b0;
                end
            end
        end
    end

    // Protocol assertion failures end the run
    always @(posedge clk_i) begin
        if (u_dut.u_sva.fail_count != 0) begin
            stop_with_error("a protocol assertion failed");
        end
    end

    ////////////////////////////////////////
    // Pattern replay
    ////////////////////////////////////////

    initial begin
        int   i;
        int   waited;
        logic granted;
        clk_i         = 1'b0;
        reset_i       = 1'b1;
        fc_req_i      = 1'b0;
        fc_add_i      = '0;
        fc_wen_i      = 1'b1;
        fc_wdata_i    = '0;
        fc_be_i       = '0;
        mem_gnt_i     = 1'b0;
        mem_r_valid_i = 1'b0;
        mem_r_rdata_i = '0;
        apb_pready_i  = 1'b0;
        apb_prdata_i  = '0;
        apb_pslverr_i = 1'b0;
        apb_pend      = 1'b0;
        cur_idx       = 0;
        void'($urandom(32'h9dfe));
        load_patterns();
        if (pat_wen.size() == 0) begin
            stop_with_error("the pattern file holds no transactions");
        end
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        @(posedge clk_i);
        // Requests go out back to back with the next one right after a grant
        for (i = 0; i < pat_wen.size(); i++) begin
            fc_req_i   <= 1'b1;
            fc_add_i   <= pat_addr[i];
            fc_wen_i   <= pat_wen[i];
            fc_wdata_i <= pat_wdata[i];
            fc_be_i    <= pat_be[i];
            cur_idx    <= i;
            waited  = 0;
            granted = 1'b0;
            while (!granted) begin
                @(posedge clk_i);
                if (fc_gnt_o) begin
                    granted = 1'b1;
                end else begin
                    waited++;
                    if (waited > GNT_TIMEOUT) begin
                        stop_with_error("request never granted");
                    end
                end
            end
            record_grant(i);
        end
        fc_req_i <= 1'b0;
        waited = 0;
        while (resp_q.size() != 0) begin
            @(posedge clk_i);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                stop_with_error("responses still missing at the end of the run");
            end
        end
        repeat (2) @(posedge clk_i);
        if (u_dut.u_sva.fail_count != 0) begin
            stop_with_error("a protocol assertion failed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* bench/soc_xbar_patterns.txt */
# wen addr wdata be wait slverr port sel exp_addr exp_rdata exp_opc
# wen 1 is read, wait in cycles, port 0 none 1 mem 2 apb, sel 0 bank0 1 bank1 2 rom
1 00000010 00000000 f 0 0 1 0 1c000010 465a5a4a 0
1 1c000000 00000000 f 0 0 1 0 1c000000 465a5a5a 0
1 1c007ffc 00000000 f 0 0 1 0 1c007ffc 465a25a6 0
1 1c008000 00000000 f 0 0 1 1 1c008000 465ada5a 0
1 1c00fffc 00000000 f 0 0 1 1 1c00fffc 465aa5a6 0
1 1a000000 00000000 f 0 0 1 2 1a000000 405a5a5a 0
1 1a003ffc 00000000 f 0 0 1 2 1a003ffc 405a65a6 0
0 1c000020 1234abcd 3 0 0 1 0 1c000020 00000000 0
1 1c000020 00000000 f 0 0 1 0 1c000020 465aabcd 0
1 00008004 00000000 f 0 0 1 1 1c008004 465ada5e 0
0 1a000100 deadbeef f 0 0 0 0 1a000100 00000000 1
1 30000000 00000000 f 0 0 0 0 30000000 00000000 1
1 1c010000 00000000 f 0 0 0 0 1c010000 00000000 1
1 00010000 00000000 f 0 0 0 0 1c010000 00000000 1
1 1a004000 00000000 f 0 0 0 0 1a004000 00000000 1
1 1a100000 00000000 f 0 0 2 0 1a100000 d9d33c3c 0
0 1a102000 00c0ffee c 2 0 2 0 1a102000 00000000 0
1 1a1ffff0 00000000 f 1 1 2 0 1a1ffff0 d9dcc3cc 1
1 1c000004 00000000 f 0 0 1 0 1c000004 465a5a5e 0
1 1a100104 00000000 f 15 0 2 0 1a100104 d9d33d38 0
1 1a100100 00000000 f 20 0 2 0 1a100100 00000000 1
1 40000000 00000000 f 0 0 0 0 40000000 00000000 1
0 1c008010 cafef00d f 0 0 1 1 1c008010 00000000 0
1 1c008010 00000000 f 0 0 1 1 1c008010 cafef00d 0

/* sim.f */
+incdir+common
common/soc_xbar_pkg.sv
rtl/soc_addr_decode.sv
rtl/soc_contig_router.sv
apb_bridge/apb_timeout_counter.sv
apb_bridge/apb_bridge_fsm.sv
rtl/soc_xbar_top.sv
bench/soc_xbar_sva.sv
bench/tb_soc_xbar.sv
